// File: logic/dp_pkg.sv
`default_nettype none

package dp_pkg;

    // --------------------
    // Field widths

    localparam int WORD_W = 16;                 // Data word
    localparam int OP_W   = 4;                  // Opcode field
    localparam int D_W    = 8;                  // Destination field
    localparam int SRC_W  = 6;                  // Source address field

    // --------------------
    // Opcodes

    // Codes 7 to 15 are not listed and act as NOP
    typedef enum logic [OP_W-1:0] {
        NOP    = 4'd0,
        ADD    = 4'd1,
        SUB    = 4'd2,                          // A minus B, wraps
        AND    = 4'd3,
        OR     = 4'd4,
        XOR    = 4'd5,
        PASS_A = 4'd6
    } op_e;

    // --------------------
    // Structs between blocks

    typedef struct packed {
        logic [OP_W-1:0]  op;
        logic [D_W-1:0]   d;
        logic [SRC_W-1:0] a;
        logic [SRC_W-1:0] b;
    } instr_t;                                  // 24 bits

    typedef struct packed {
        logic rd_has_data;                      // Read port holds a word
        logic wr_has_space;                     // Write port can take a word
    } io_status_t;

    typedef struct packed {
        logic             write_a;              // RAM write into bank A
        logic             write_b;              // RAM write into bank B
        logic             io_wr_a;
        logic             io_wr_b;
        logic [SRC_W-1:0] ram_addr;             // Bank-local offset
    } dest_t;

    typedef struct packed {
        logic [OP_W-1:0] op;                    // NOP when annulled
        logic [D_W-1:0]  d;
        dest_t           dest;
        logic            a_from_io;
        logic            b_from_io;
    } issue_t;

    typedef struct packed {
        logic              valid;
        logic [D_W-1:0]    d;
        logic [WORD_W-1:0] value;
    } result_t;

endpackage

`default_nettype wire

// File: logic/issue_gate.sv
`default_nettype none

module issue_gate #(
    parameter int BANK_DEPTH   = 48,
    parameter int IO_PORT_ADDR = 48,
    parameter int B_WRITE_BASE = 64
) (
    input  wire dp_pkg::instr_t     instr,
    input  wire                     cancel,
    input  wire dp_pkg::io_status_t io_stat_a,
    input  wire dp_pkg::io_status_t io_stat_b,

    output logic                    io_ready,
    output logic                    io_rden_a,
    output logic                    io_rden_b,
    output dp_pkg::issue_t          issue,
    output logic [dp_pkg::SRC_W-1:0] rd_addr_a,
    output logic [dp_pkg::SRC_W-1:0] rd_addr_b
);

    localparam int                     WIN     = 2 ** dp_pkg::SRC_W;  // Window width
    localparam logic [dp_pkg::D_W-1:0] B_BASE  = B_WRITE_BASE[dp_pkg::D_W-1:0];
    localparam logic [dp_pkg::SRC_W-1:0] IO_ADDR = IO_PORT_ADDR[dp_pkg::SRC_W-1:0];

    logic                     a_is_io;
    logic                     b_is_io;
    logic                     in_win_a;
    logic                     in_win_b;
    logic [dp_pkg::D_W-1:0]   b_rel;
    logic [dp_pkg::SRC_W-1:0] offset;
    logic                     hit_ram;
    logic                     hit_io;
    dp_pkg::dest_t            dest_raw;

    // --------------------
    // Source and destination decode

    assign a_is_io = (instr.a == IO_ADDR);
    assign b_is_io = (instr.b == IO_ADDR);

    assign b_rel    = instr.d - B_BASE;
    assign in_win_a = (instr.d < WIN);
    assign in_win_b = !in_win_a && (instr.d >= B_BASE) && (b_rel < WIN);  // A wins on overlap
    assign offset   = in_win_b ? b_rel[dp_pkg::SRC_W-1:0] : instr.d[dp_pkg::SRC_W-1:0];

    assign hit_ram = (offset < BANK_DEPTH);
    assign hit_io  = (offset == IO_ADDR);

    always_comb begin
        dest_raw          = '0;                 // Outside both windows is discarded
        dest_raw.write_a  = in_win_a && hit_ram;
        dest_raw.write_b  = in_win_b && hit_ram;
        dest_raw.io_wr_a  = in_win_a && hit_io;
        dest_raw.io_wr_b  = in_win_b && hit_io;
        dest_raw.ram_addr = offset;
    end

    // --------------------
    // Readiness and annul

    assign io_ready = !cancel
                    && (!a_is_io || io_stat_a.rd_has_data)
                    && (!b_is_io || io_stat_b.rd_has_data)
                    && (!dest_raw.io_wr_a || io_stat_a.wr_has_space)
                    && (!dest_raw.io_wr_b || io_stat_b.wr_has_space);

    assign io_rden_a = io_ready && a_is_io;     // Pop only on a real issue
    assign io_rden_b = io_ready && b_is_io;

    always_comb begin
        issue.d = instr.d;
        if (io_ready) begin
            issue.op        = instr.op;
            issue.dest      = dest_raw;
            issue.a_from_io = a_is_io;
            issue.b_from_io = b_is_io;
        end else begin
            issue.op        = dp_pkg::NOP;      // No side effect downstream
            issue.dest      = '0;
            issue.a_from_io = 1'b0;
            issue.b_from_io = 1'b0;
        end
    end

    assign rd_addr_a = instr.a;
    assign rd_addr_b = instr.b;

endmodule

`default_nettype wire

// File: logic/operand_bank.sv
`default_nettype none

module operand_bank #(
    parameter int BANK_DEPTH   = 48,
    parameter int IO_PORT_ADDR = 48
) (
    input  wire                       clock,
    input  wire                       arst_n,

    input  wire [dp_pkg::SRC_W-1:0]   rd_addr,
    input  wire                       rd_from_io,
    input  wire [dp_pkg::WORD_W-1:0]  io_in,

    input  wire                       wr_en,
    input  wire [dp_pkg::SRC_W-1:0]   wr_addr,
    input  wire [dp_pkg::WORD_W-1:0]  wr_data,

    output logic [dp_pkg::WORD_W-1:0] rd_data
);

    localparam logic [dp_pkg::SRC_W-1:0] IO_ADDR = IO_PORT_ADDR[dp_pkg::SRC_W-1:0];

    logic [dp_pkg::WORD_W-1:0] mem [BANK_DEPTH];
    logic                      rd_is_ram;

    // --------------------
    // Word array

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < BANK_DEPTH; i++) begin
                mem[i] <= '0;                   // Banks start cleared
            end
        end else if (wr_en && (wr_addr < BANK_DEPTH)) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // --------------------
    // Registered read

    // IO_ADDR sits above the RAM, so an unflagged access to it reads zero
    assign rd_is_ram = (rd_addr < BANK_DEPTH) && (rd_addr != IO_ADDR);

    always_ff @(posedge clock) begin
        if (rd_from_io) begin
            rd_data <= io_in;                   // Word on the I/O read port
        end else if (rd_is_ram) begin
            rd_data <= mem[rd_addr];            // Old value on a same-edge write
        end else begin
            rd_data <= '0;                      // Unmapped
        end
    end

endmodule

`default_nettype wire

// File: logic/alu_stage.sv
`default_nettype none

module alu_stage (
    input  wire                       clock,
    input  wire                       arst_n,

    input  wire dp_pkg::issue_t       issue,
    input  wire [dp_pkg::WORD_W-1:0]  opnd_a,
    input  wire [dp_pkg::WORD_W-1:0]  opnd_b,

    output dp_pkg::result_t           res,
    output dp_pkg::dest_t             dest
);

    logic [dp_pkg::OP_W-1:0]   op_q;
    logic [dp_pkg::D_W-1:0]    d_q;
    dp_pkg::dest_t             dest_q;
    logic                      valid;
    logic [dp_pkg::WORD_W-1:0] value;

    // --------------------
    // Hold while operands are read

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            op_q   <= dp_pkg::NOP;
            d_q    <= '0;
            dest_q <= '0;
        end else begin
            op_q   <= issue.op;
            d_q    <= issue.d;
            dest_q <= issue.dest;
        end
    end

    // --------------------
    // Operation

    always_comb begin
        valid = 1'b1;
        value = '0;
        case (op_q)
            dp_pkg::ADD:    value = opnd_a + opnd_b;
            dp_pkg::SUB:    value = opnd_a - opnd_b;    // Modulo 2^16
            dp_pkg::AND:    value = opnd_a & opnd_b;
            dp_pkg::OR:     value = opnd_a | opnd_b;
            dp_pkg::XOR:    value = opnd_a ^ opnd_b;
            dp_pkg::PASS_A: value = opnd_a;
            default:        valid = 1'b0;               // NOP and codes 7 to 15
        endcase
    end

    // --------------------
    // Result register

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            res  <= '0;
            dest <= '0;
        end else begin
            res.valid <= valid;
            res.d     <= d_q;
            res.value <= value;
            dest      <= dest_q;
        end
    end

endmodule

`default_nettype wire

// File: logic/writeback.sv
`default_nettype none

module writeback (
    input  wire                       clock,
    input  wire                       arst_n,

    input  wire dp_pkg::result_t      res,
    input  wire dp_pkg::dest_t        dest,

    output logic                      wr_en_a,
    output logic                      wr_en_b,
    output logic [dp_pkg::SRC_W-1:0]  wr_addr,
    output logic [dp_pkg::WORD_W-1:0] wr_data,

    output logic                      io_wren_a,
    output logic                      io_wren_b,
    output logic [dp_pkg::WORD_W-1:0] io_out_a,
    output logic [dp_pkg::WORD_W-1:0] io_out_b,

    output dp_pkg::result_t           result
);

    logic io_hit_a;
    logic io_hit_b;

    // --------------------
    // Bank RAM writes

    assign wr_en_a = res.valid && dest.write_a;         // Commits at the next edge
    assign wr_en_b = res.valid && dest.write_b;
    assign wr_addr = dest.ram_addr;                     // Shared by both banks
    assign wr_data = res.value;

    // --------------------
    // I/O writes and result

    assign io_hit_a = res.valid && dest.io_wr_a;
    assign io_hit_b = res.valid && dest.io_wr_b;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            io_wren_a <= 1'b0;
            io_wren_b <= 1'b0;
            io_out_a  <= '0;
            io_out_b  <= '0;
            result    <= '0;
        end else begin
            io_wren_a <= io_hit_a;                      // One-cycle pulse
            io_wren_b <= io_hit_b;
            if (io_hit_a) begin
                io_out_a <= res.value;                  // Held until the next write
            end
            if (io_hit_b) begin
                io_out_b <= res.value;
            end
            result <= res;                              // Valid even when discarded
        end
    end

endmodule

`default_nettype wire

// File: logic/dp_top.sv
`default_nettype none

module dp_top #(
    parameter int BANK_DEPTH   = 48,
    parameter int IO_PORT_ADDR = 48,
    parameter int B_WRITE_BASE = 64
) (
    input  wire                        clock,
    input  wire                        arst_n,

    input  wire dp_pkg::instr_t        instr,
    input  wire                        cancel,
    output logic                       io_ready,

    input  wire dp_pkg::io_status_t    io_stat_a,
    input  wire dp_pkg::io_status_t    io_stat_b,
    input  wire [dp_pkg::WORD_W-1:0]   io_in_a,
    input  wire [dp_pkg::WORD_W-1:0]   io_in_b,
    output logic                       io_rden_a,
    output logic                       io_rden_b,

    output logic                       io_wren_a,
    output logic                       io_wren_b,
    output logic [dp_pkg::WORD_W-1:0]  io_out_a,
    output logic [dp_pkg::WORD_W-1:0]  io_out_b,

    output dp_pkg::result_t            result
);

    dp_pkg::issue_t            issue;
    logic [dp_pkg::SRC_W-1:0]  rd_addr_a;
    logic [dp_pkg::SRC_W-1:0]  rd_addr_b;
    logic [dp_pkg::WORD_W-1:0] opnd_a;
    logic [dp_pkg::WORD_W-1:0] opnd_b;
    dp_pkg::result_t           alu_res;
    dp_pkg::dest_t             alu_dest;
    logic                      wr_en_a;
    logic                      wr_en_b;
    logic [dp_pkg::SRC_W-1:0]  wr_addr;
    logic [dp_pkg::WORD_W-1:0] wr_data;

    // --------------------
    // Cycle 0

    issue_gate #(
        .BANK_DEPTH   (BANK_DEPTH),
        .IO_PORT_ADDR (IO_PORT_ADDR),
        .B_WRITE_BASE (B_WRITE_BASE)
    ) issue_gate_i (
        .instr        (instr),
        .cancel       (cancel),
        .io_stat_a    (io_stat_a),
        .io_stat_b    (io_stat_b),
        .io_ready     (io_ready),
        .io_rden_a    (io_rden_a),
        .io_rden_b    (io_rden_b),
        .issue        (issue),
        .rd_addr_a    (rd_addr_a),
        .rd_addr_b    (rd_addr_b)
    );

    // --------------------
    // Operand banks, read at E0 and written at E2

    operand_bank #(
        .BANK_DEPTH   (BANK_DEPTH),
        .IO_PORT_ADDR (IO_PORT_ADDR)
    ) bank_a_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .rd_addr      (rd_addr_a),
        .rd_from_io   (issue.a_from_io),
        .io_in        (io_in_a),
        .wr_en        (wr_en_a),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_data      (opnd_a)
    );

    operand_bank #(
        .BANK_DEPTH   (BANK_DEPTH),
        .IO_PORT_ADDR (IO_PORT_ADDR)
    ) bank_b_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .rd_addr      (rd_addr_b),
        .rd_from_io   (issue.b_from_io),
        .io_in        (io_in_b),
        .wr_en        (wr_en_b),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .rd_data      (opnd_b)
    );

    // --------------------
    // ALU, result at E1

    alu_stage alu_stage_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .issue        (issue),
        .opnd_a       (opnd_a),
        .opnd_b       (opnd_b),
        .res          (alu_res),
        .dest         (alu_dest)
    );

    // --------------------
    // Writeback, outputs in cycle 3

    writeback writeback_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .res          (alu_res),
        .dest         (alu_dest),
        .wr_en_a      (wr_en_a),
        .wr_en_b      (wr_en_b),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .io_wren_a    (io_wren_a),
        .io_wren_b    (io_wren_b),
        .io_out_a     (io_out_a),
        .io_out_b     (io_out_b),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: dv/dp_assert.sv
`default_nettype none

module dp_assert (
    input wire                     clock,
    input wire                     arst_n,
    input wire                     cancel,
    input wire                     io_ready,
    input wire                     io_rden_a,
    input wire                     io_rden_b,
    input wire dp_pkg::io_status_t io_stat_a,
    input wire dp_pkg::io_status_t io_stat_b,
    input wire                     io_wren_a,
    input wire                     io_wren_b,
    input wire dp_pkg::result_t    result
);

    timeunit 1ns;
    timeprecision 100ps;

    // --------------------
    // Read pulses only on an accepted issue

    rden_a_ok: assert property (@(posedge clock) disable iff (!arst_n)
        io_rden_a |-> io_ready && io_stat_a.rd_has_data)
        else $error("io_rden_a without io_ready or read data on port A");

    rden_b_ok: assert property (@(posedge clock) disable iff (!arst_n)
        io_rden_b |-> io_ready && io_stat_b.rd_has_data)
        else $error("io_rden_b without io_ready or read data on port B");

    // --------------------
    // Write pulses travel with a valid result

    wren_a_ok: assert property (@(posedge clock) disable iff (!arst_n)
        io_wren_a |-> result.valid)
        else $error("io_wren_a without a valid result");

    wren_b_ok: assert property (@(posedge clock) disable iff (!arst_n)
        io_wren_b |-> result.valid)
        else $error("io_wren_b without a valid result");

    ready_ok: assert property (@(posedge clock) disable iff (!arst_n)
        io_ready |-> !cancel)
        else $error("io_ready high while cancel is high");

endmodule

`default_nettype wire

// File: dv/dp_tb.sv
`default_nettype none

module dp_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BANK_DEPTH   = 48;
    localparam int IO_PORT_ADDR = 48;
    localparam int B_WRITE_BASE = 64;
    localparam int MAX_TRIES    = 32;                   // Presentations per instruction

    typedef struct packed {
        logic                      valid;
        logic [dp_pkg::D_W-1:0]    d;
        logic [dp_pkg::WORD_W-1:0] value;
        logic                      wr_a;
        logic                      wr_b;
        logic                      io_a;
        logic                      io_b;
        logic [dp_pkg::SRC_W-1:0]  addr;
    } expect_t;                                         // Model outputs of one instruction

    logic                      clock;
    logic                      arst_n;
    dp_pkg::instr_t            instr;
    logic                      cancel;
    dp_pkg::io_status_t        io_stat_a;
    dp_pkg::io_status_t        io_stat_b;
    logic [dp_pkg::WORD_W-1:0] io_in_a;
    logic [dp_pkg::WORD_W-1:0] io_in_b;
    logic                      io_ready;
    logic                      io_rden_a;
    logic                      io_rden_b;
    logic                      io_wren_a;
    logic                      io_wren_b;
    logic [dp_pkg::WORD_W-1:0] io_out_a;
    logic [dp_pkg::WORD_W-1:0] io_out_b;
    dp_pkg::result_t           result;

    logic [31:0]               rng_state = 32'd3609;
    logic [dp_pkg::WORD_W-1:0] bank_a [BANK_DEPTH];    // Model banks
    logic [dp_pkg::WORD_W-1:0] bank_b [BANK_DEPTH];
    logic [dp_pkg::WORD_W-1:0] model_out_a;
    logic [dp_pkg::WORD_W-1:0] model_out_b;
    expect_t                   pipe_q [$];              // Instructions in flight, oldest first
    int                        checks;
    int                        errors;
    int                        test_errors;

    dp_top #(
        .BANK_DEPTH   (BANK_DEPTH),
        .IO_PORT_ADDR (IO_PORT_ADDR),
        .B_WRITE_BASE (B_WRITE_BASE)
    ) dut_i (
        .clock (clock), .arst_n (arst_n), .instr (instr), .cancel (cancel),
        .io_ready (io_ready), .io_stat_a (io_stat_a), .io_stat_b (io_stat_b),
        .io_in_a (io_in_a), .io_in_b (io_in_b), .io_rden_a (io_rden_a),
        .io_rden_b (io_rden_b), .io_wren_a (io_wren_a), .io_wren_b (io_wren_b),
        .io_out_a (io_out_a), .io_out_b (io_out_b), .result (result)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        #100000;
        $display("Timeout: the simulation ran past its time limit");
        $display("TB FAILED");
        $finish;
    end

    // --------------------
    // Helpers

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic chance(input int percent);
        logic [31:0] r;
        r = xorshift();
        return (r % 100) < percent;
    endfunction

    function automatic logic [dp_pkg::SRC_W-1:0] ram_addr();
        logic [31:0] r;
        r = xorshift();
        if (r[31]) begin
            return 6'(r % 8);                           // Narrow range, many hazards
        end
        return 6'(r % BANK_DEPTH);
    endfunction

    function automatic logic [15:0] operand(input logic [5:0] addr, input logic [15:0] io_word,
                                            input logic from_b);
        if (addr == IO_PORT_ADDR) begin
            return io_word;
        end
        if (addr < BANK_DEPTH) begin
            return from_b ? bank_b[addr] : bank_a[addr];
        end
        return '0;                                      // Unmapped source
    endfunction

    function automatic logic [16:0] alu_model(input logic [3:0] op, input logic [15:0] a,
                                              input logic [15:0] b);
        case (op)
            dp_pkg::ADD:    return {1'b1, a + b};
            dp_pkg::SUB:    return {1'b1, a - b};
            dp_pkg::AND:    return {1'b1, a & b};
            dp_pkg::OR:     return {1'b1, a | b};
            dp_pkg::XOR:    return {1'b1, a ^ b};
            dp_pkg::PASS_A: return {1'b1, a};
            default:        return '0;                  // NOP
        endcase
    endfunction

    task automatic check(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            errors++;
            test_errors++;
            $display("CHECK FAILED at %0d ns: %s", $time, what);
        end
    endtask

    // --------------------
    // One cycle: check outputs, then present an instruction

    task automatic step(input dp_pkg::instr_t ins, input logic cxl, input dp_pkg::io_status_t sa,
                        input dp_pkg::io_status_t sb, output logic accepted);
        expect_t     old;
        expect_t     e;
        logic [31:0] r;
        logic [7:0]  off;
        logic [16:0] alu;
        logic        in_a;
        logic        in_b;
        logic        rdy;
        @(negedge clock);
        old = pipe_q.pop_front();                       // Issued three cycles ago
        check(result.valid === old.valid, $sformatf("result.valid %b, want %b",
              result.valid, old.valid));
        if (old.valid) begin
            check(result.d === old.d, $sformatf("result.d %0d, want %0d", result.d, old.d));
            check(result.value === old.value, $sformatf("result.value %h, want %h",
                  result.value, old.value));
        end
        check(io_wren_a === old.io_a, $sformatf("io_wren_a %b, want %b", io_wren_a, old.io_a));
        check(io_wren_b === old.io_b, $sformatf("io_wren_b %b, want %b", io_wren_b, old.io_b));
        if (old.wr_a) begin
            bank_a[old.addr] = old.value;               // Committed at the last edge
        end
        if (old.wr_b) begin
            bank_b[old.addr] = old.value;
        end
        model_out_a = old.io_a ? old.value : model_out_a;
        model_out_b = old.io_b ? old.value : model_out_b;
        check(io_out_a === model_out_a, $sformatf("io_out_a %h, want %h", io_out_a, model_out_a));
        check(io_out_b === model_out_b, $sformatf("io_out_b %h, want %h", io_out_b, model_out_b));

        r         = xorshift();
        instr     = ins;
        cancel    = cxl;
        io_stat_a = sa;
        io_stat_b = sb;
        io_in_a   = r[15:0];
        io_in_b   = r[31:16];

        in_a = (ins.d < 8'd64);
        in_b = !in_a && (ins.d >= B_WRITE_BASE) && (ins.d < B_WRITE_BASE + 64);
        off  = in_b ? 8'(ins.d - B_WRITE_BASE) : ins.d;
        rdy  = !cxl
             && (ins.a != IO_PORT_ADDR || sa.rd_has_data)
             && (ins.b != IO_PORT_ADDR || sb.rd_has_data)
             && !(in_a && off == IO_PORT_ADDR && !sa.wr_has_space)
             && !(in_b && off == IO_PORT_ADDR && !sb.wr_has_space);
        alu = alu_model(ins.op, operand(ins.a, r[15:0], 1'b0), operand(ins.b, r[31:16], 1'b1));
        e       = '0;
        e.valid = rdy && alu[16];
        e.d     = ins.d;
        e.value = alu[15:0];
        e.addr  = off[5:0];
        e.wr_a  = e.valid && in_a && (off < BANK_DEPTH);
        e.wr_b  = e.valid && in_b && (off < BANK_DEPTH);
        e.io_a  = e.valid && in_a && (off == IO_PORT_ADDR);
        e.io_b  = e.valid && in_b && (off == IO_PORT_ADDR);
        pipe_q.push_back(e);

        #1;                                             // Let the issue decode settle
        check(io_ready === rdy, $sformatf("io_ready %b, want %b", io_ready, rdy));
        check(io_rden_a === (rdy && ins.a == IO_PORT_ADDR), "io_rden_a mismatch");
        check(io_rden_b === (rdy && ins.b == IO_PORT_ADDR), "io_rden_b mismatch");
        accepted = io_ready;
    endtask

    // --------------------
    // Random instruction stream, re-presented until accepted

    task automatic run_test(input string name, input int count, input int p_io_rd,
                            input int p_io_wr, input int p_busy, input int p_cancel,
                            input int p_skip);
        dp_pkg::instr_t     ins;
        dp_pkg::io_status_t sa;
        dp_pkg::io_status_t sb;
        logic [31:0]        r;
        logic [5:0]         off;
        logic               cxl;
        logic               accepted;
        int                 tries;
        test_errors = 0;
        for (int n = 0; n < count; n++) begin
            r      = xorshift();
            ins.op = (r[3:0] < 4'd12) ? 4'(1 + r[3:0] % 6) : r[3:0];   // Mostly real ops
            ins.a  = chance(p_io_rd) ? 6'(IO_PORT_ADDR) : ram_addr();
            ins.b  = chance(p_io_rd) ? 6'(IO_PORT_ADDR) : ram_addr();
            off    = chance(p_io_wr) ? 6'(IO_PORT_ADDR) : ram_addr();
            ins.d  = r[4] ? 8'(B_WRITE_BASE) + {2'b0, off} : {2'b0, off};
            if (chance(p_skip)) begin
                ins.d = r[5] ? {1'b1, r[22:16]} : 8'(49 + r[19:16] % 15);
            end
            if (chance(p_skip)) begin
                ins.b = 6'(BANK_DEPTH + 1 + xorshift() % (63 - BANK_DEPTH));   // Unmapped source
            end
            accepted = 1'b0;
            tries    = 0;
            while (!accepted && tries < MAX_TRIES) begin
                sa.rd_has_data  = !chance(p_busy);
                sa.wr_has_space = !chance(p_busy);
                sb.rd_has_data  = !chance(p_busy);
                sb.wr_has_space = !chance(p_busy);
                cxl             = chance(p_cancel);
                step(ins, cxl, sa, sb, accepted);
                tries++;
            end
            if (!accepted) begin
                errors++;
                test_errors++;
                $display("Instruction %0d was not accepted after %0d tries", n, MAX_TRIES);
            end
        end
        for (int k = 0; k < 3; k++) begin
            step('0, 1'b0, '1, '1, accepted);           // Drain the pipeline
        end
        $display("test %-20s %0d instructions, %0d errors", name, count, test_errors);
    endtask

    // --------------------
    // Sequence

    initial begin
        arst_n      = 1'b0;
        instr       = '0;
        cancel      = 1'b0;
        io_stat_a   = '0;
        io_stat_b   = '0;
        io_in_a     = '0;
        io_in_b     = '0;
        model_out_a = '0;
        model_out_b = '0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        for (int i = 0; i < BANK_DEPTH; i++) begin
            bank_a[i] = '0;
            bank_b[i] = '0;
        end

        repeat (16) begin
            @(negedge clock);
            check(!result.valid && !io_wren_a && !io_wren_b, "outputs active in reset");
            check(io_out_a === '0 && io_out_b === '0, "io_out not cleared in reset");
        end
        arst_n = 1'b1;
        repeat (3) pipe_q.push_back('0);                // Nothing issued before reset ends
        $display("test %-20s %0d errors", "reset", test_errors);

        run_test("ram arithmetic", 300, 0, 0, 0, 0, 0);
        run_test("io reads", 200, 40, 0, 30, 0, 0);
        run_test("io writes", 200, 0, 40, 30, 0, 0);
        run_test("cancel and discard", 200, 10, 10, 10, 30, 30);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    bind dp_top dp_assert dp_assert_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .cancel    (cancel),
        .io_ready  (io_ready),
        .io_rden_a (io_rden_a),
        .io_rden_b (io_rden_b),
        .io_stat_a (io_stat_a),
        .io_stat_b (io_stat_b),
        .io_wren_a (io_wren_a),
        .io_wren_b (io_wren_b),
        .result    (result)
    );

endmodule

`default_nettype wire

// File: flist.f
logic/dp_pkg.sv
logic/issue_gate.sv
logic/operand_bank.sv
logic/alu_stage.sv
logic/writeback.sv
logic/dp_top.sv
dv/dp_assert.sv
dv/dp_tb.sv

// File: Bender.yml
package:
  name: dp_core

sources:
  - logic/dp_pkg.sv
  - logic/issue_gate.sv
  - logic/operand_bank.sv
  - logic/alu_stage.sv
  - logic/writeback.sv
  - logic/dp_top.sv
  - target: test
    files:
      - dv/dp_assert.sv
      - dv/dp_tb.sv
